// File: verilog.f
hw/uart_cfg_pkg.sv
hw/uart_frame_pkg.sv
hw/byte_fifo.sv
hw/uart_tx_serializer.sv
hw/uart_rx_deserializer.sv
hw/uart.sv
tests/uart_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the uart testbench with Verilator, runs it and checks the result line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module uart_tb -o uart_sim &&
    ./obj_dir/uart_sim | tee /dev/stderr | grep -qx "PASS: all tests" &&
    echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }

// File: tests/uart_tb.sv
// uart_tb: clock, reset, line model on both pins, checks of the uart top level and a watchdog
`timescale 1ns/10ps

module uart_tb;
    import uart_cfg_pkg::*;
    import uart_frame_pkg::*;

    localparam int FIFO_DEPTH     = 4;
    localparam int CLK_PERIOD     = 100;     // ns
    localparam int CYCLES_PER_BIT = 8;
    localparam int FRAME_CYCLES   = 10 * CYCLES_PER_BIT;
    localparam int TOTAL_FRAMES   = 23;      // 5 + 8 tx offers, 3 + 6 rx frames, glitch window
    localparam int WATCHDOG_NS    = TOTAL_FRAMES * FRAME_CYCLES * CLK_PERIOD * 2;

    logic       clk;
    logic       rst;
    baud_div_t  baud_div;
    logic       tx_start;
    data_byte_t tx_data;
    logic       tx_pin;
    logic       tx_fifo_full;
    logic       rx_pin;
    logic       rx_read;
    logic       rx_ready;
    data_byte_t rx_byte;

    data_byte_t tx_expect[$];                // bytes the tx line must still carry, in order
    data_byte_t rx_expect[$];                // bytes the RX FIFO must hand out, in order
    logic       tx_quiet;                    // tx_pin has to stay at the idle level
    logic       rx_quiet;                    // nothing may show up in the RX FIFO
    integer     seed;

    uart #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) uart_inst (
        .clk         (clk),
        .rst         (rst),
        .baud_div    (baud_div),
        .tx_start    (tx_start),
        .tx_data     (tx_data),
        .tx_pin      (tx_pin),
        .tx_fifo_full(tx_fifo_full),
        .rx_pin      (rx_pin),
        .rx_read     (rx_read),
        .rx_ready    (rx_ready),
        .rx_byte     (rx_byte)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [15:0] expected,
                                   input logic [15:0] actual);
        $display("** Error at time %0t: %s expected 0x%0h, actual 0x%0h",
                 $time, name, expected, actual);
        abort_run();
    endtask

    task automatic report_problem(input string what);
        $display("** Error at time %0t: %s", $time, what);
        abort_run();
    endtask

    // outputs back at their reset levels one cycle after every reset edge
    reset_tx_pin: assert property (@(posedge clk) !rst |=> tx_pin)
        else report_mismatch("tx_pin", 16'd1, 16'($sampled(tx_pin)));
    reset_tx_full: assert property (@(posedge clk) !rst |=> !tx_fifo_full)
        else report_mismatch("tx_fifo_full", 16'd0, 16'($sampled(tx_fifo_full)));
    reset_rx_ready: assert property (@(posedge clk) !rst |=> !rx_ready)
        else report_mismatch("rx_ready", 16'd0, 16'($sampled(rx_ready)));

    idle_tx_line: assert property (@(posedge clk) tx_quiet |-> tx_pin)
        else report_mismatch("tx_pin", 16'd1, 16'($sampled(tx_pin)));
    idle_rx_fifo: assert property (@(posedge clk) rx_quiet |-> !rx_ready)
        else report_mismatch("rx_ready", 16'd0, 16'($sampled(rx_ready)));

    // inputs change a little after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic offer_byte(input data_byte_t b, output logic accepted);
        accepted = !tx_fifo_full;            // a full FIFO drops the offer
        tx_start = 1'b1;
        tx_data  = b;
        if (accepted) tx_expect.push_back(b);
        next_cycle();
        tx_start = 1'b0;
    endtask

    task automatic drain_tx();
        while (tx_expect.size() != 0) next_cycle();   // watchdog bounds this
    endtask

    // decodes one frame on tx_pin, sampled at mid-bit on the falling clock edge
    task automatic decode_tx_frame(output data_byte_t b);
        @(negedge tx_pin);
        repeat (CYCLES_PER_BIT / 2) @(posedge clk);
        @(negedge clk);
        assert (tx_pin == 1'b0) else report_mismatch("tx_pin start bit", 16'd0, 16'(tx_pin));
        for (int i = 0; i < DATA_BITS; i++) begin
            repeat (CYCLES_PER_BIT) @(negedge clk);
            b[i] = tx_pin;                   // LSB first
        end
        repeat (CYCLES_PER_BIT) @(negedge clk);
        assert (tx_pin == 1'b1) else report_mismatch("tx_pin stop bit", 16'd1, 16'(tx_pin));
    endtask

    task automatic send_frame(input data_byte_t b);
        rx_pin = 1'b0;                       // start bit
        repeat (CYCLES_PER_BIT) next_cycle();
        for (int i = 0; i < DATA_BITS; i++) begin
            rx_pin = b[i];
            repeat (CYCLES_PER_BIT) next_cycle();
        end
        rx_pin = 1'b1;                       // stop bit
        repeat (CYCLES_PER_BIT) next_cycle();
    endtask

    task automatic read_byte();
        int         waited;
        data_byte_t want;
        waited = 0;
        while (!rx_ready && waited < 2 * FRAME_CYCLES) begin
            next_cycle();
            waited++;
        end
        if (!rx_ready) begin
            report_problem("rx_ready did not rise within two frame times");
        end else if (rx_expect.size() == 0) begin
            report_problem("no received byte is expected but rx_ready is high");
        end else begin
            want = rx_expect.pop_front();
            assert (rx_byte == want) else report_mismatch("rx_byte", 16'(want), 16'(rx_byte));
            rx_read = 1'b1;
            next_cycle();
            rx_read = 1'b0;
        end
    endtask

    initial begin : tx_line_monitor
        data_byte_t got;
        data_byte_t want;
        wait (rst === 1'b1);
        forever begin
            decode_tx_frame(got);
            if (tx_expect.size() == 0) begin
                report_problem("frame on tx_pin while no byte was queued");
            end else begin
                want = tx_expect.pop_front();
                assert (got == want) else report_mismatch("tx_pin data", 16'(want), 16'(got));
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, a test did not complete", WATCHDOG_NS);
        abort_run();
    end

    initial begin : stimulus
        data_byte_t b;
        logic       accepted;
        logic       saw_full;
        int         gap;
        seed     = 74;
        rst      = 1'b0;
        baud_div = baud_div_t'(CYCLES_PER_BIT - 1);
        tx_start = 1'b0;
        tx_data  = '0;
        rx_pin   = 1'b1;
        rx_read  = 1'b0;
        tx_quiet = 1'b0;
        rx_quiet = 1'b0;
        repeat (4) next_cycle();
        rst = 1'b1;

        $display("test 1: reset values");
        assert (tx_pin == 1'b1) else report_mismatch("tx_pin", 16'd1, 16'(tx_pin));
        assert (!tx_fifo_full) else report_mismatch("tx_fifo_full", 16'd0, 16'(tx_fifo_full));
        assert (!rx_ready) else report_mismatch("rx_ready", 16'd0, 16'(rx_ready));
        tx_quiet = 1'b1;
        rx_quiet = 1'b1;
        repeat (FRAME_CYCLES / 2) next_cycle();
        tx_quiet = 1'b0;
        rx_quiet = 1'b0;

        $display("test 2: tx frame order and format");
        for (int n = 0; n < 5; n++) begin
            b = data_byte_t'($random(seed));
            offer_byte(b, accepted);
            assert (accepted) else report_mismatch("tx_fifo_full", 16'd0, 16'd1);
            gap = int'($unsigned($random(seed)) % 20);
            repeat (gap) next_cycle();
        end
        drain_tx();

        $display("test 3: tx FIFO full and drop");
        saw_full = 1'b0;
        for (int n = 0; n < 8; n++) begin
            b = data_byte_t'($random(seed));
            offer_byte(b, accepted);
            if (!accepted) saw_full = 1'b1;
        end
        assert (saw_full) else report_problem("tx_fifo_full never rose during the burst");
        drain_tx();
        tx_quiet = 1'b1;                     // no dropped byte may follow
        repeat (FRAME_CYCLES) next_cycle();
        tx_quiet = 1'b0;
        assert (!tx_fifo_full) else report_mismatch("tx_fifo_full", 16'd0, 16'(tx_fifo_full));

        $display("test 4: rx receive and read");
        for (int n = 0; n < 3; n++) begin
            b = data_byte_t'($random(seed));
            rx_expect.push_back(b);
            send_frame(b);
        end
        repeat (3) read_byte();
        assert (!rx_ready) else report_mismatch("rx_ready", 16'd0, 16'(rx_ready));

        $display("test 5: rx overflow");
        for (int n = 0; n < 6; n++) begin
            b = data_byte_t'($random(seed));
            if (n < FIFO_DEPTH) rx_expect.push_back(b);   // later bytes are lost
            send_frame(b);
        end
        repeat (FIFO_DEPTH) read_byte();
        assert (!rx_ready) else report_mismatch("rx_ready", 16'd0, 16'(rx_ready));
        rx_quiet = 1'b1;
        repeat (FRAME_CYCLES) next_cycle();
        rx_quiet = 1'b0;

        $display("test 6: glitch rejection");
        rx_quiet = 1'b1;
        rx_pin   = 1'b0;                     // two cycles low, far shorter than half a bit
        repeat (2) next_cycle();
        rx_pin = 1'b1;
        repeat (FRAME_CYCLES) next_cycle();
        rx_quiet = 1'b0;

        $display("PASS: all tests");
        $finish;
    end

endmodule : uart_tb

// File: hw/uart.sv
// uart: full-duplex 8N1 top level with a byte FIFO on the transmit and receive paths
`timescale 1ns/10ps

module uart #(
    parameter int FIFO_DEPTH = uart_cfg_pkg::DEFAULT_FIFO_DEPTH  // power of two, at least 2
) (
    input  logic                       clk,
    input  logic                       rst,
    input  uart_cfg_pkg::baud_div_t    baud_div,

    // transmit side
    input  logic                       tx_start,    // one-cycle write strobe
    input  uart_frame_pkg::data_byte_t tx_data,
    output logic                       tx_pin,
    output logic                       tx_fifo_full,

    // receive side
    input  logic                       rx_pin,
    input  logic                       rx_read,     // one-cycle pop strobe
    output logic                       rx_ready,
    output uart_frame_pkg::data_byte_t rx_byte
);
    import uart_frame_pkg::*;

    data_byte_t tx_head;                     // next byte to serialize
    logic       tx_empty;
    logic       tx_push;
    logic       tx_load;                     // load serializer and pop FIFO together
    logic       ser_idle;

    data_byte_t rx_data;
    logic       rx_valid;
    logic       rx_full;
    logic       rx_empty;
    logic       rx_push;
    logic       rx_pop;

    // offers while full are dropped
    assign tx_push  = tx_start && !tx_fifo_full;
    assign tx_load  = ser_idle && !tx_empty;

    assign rx_push  = rx_valid && !rx_full;  // overflow bytes are lost
    assign rx_pop   = rx_read && !rx_empty;
    assign rx_ready = !rx_empty;

    byte_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) tx_fifo (
        .clk    (clk),
        .rst    (rst),
        .push   (tx_push),
        .pop    (tx_load),
        .wr_data(tx_data),
        .rd_data(tx_head),
        .full   (tx_fifo_full),
        .empty  (tx_empty)
    );

    uart_tx_serializer tx_ser (
        .clk     (clk),
        .rst     (rst),
        .baud_div(baud_div),
        .load    (tx_load),
        .data    (tx_head),
        .tx_pin  (tx_pin),
        .idle    (ser_idle)
    );

    uart_rx_deserializer rx_des (
        .clk       (clk),
        .rst       (rst),
        .baud_div  (baud_div),
        .rx_pin    (rx_pin),
        .byte_valid(rx_valid),
        .data      (rx_data)
    );

    byte_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) rx_fifo (
        .clk    (clk),
        .rst    (rst),
        .push   (rx_push),
        .pop    (rx_pop),
        .wr_data(rx_data),
        .rd_data(rx_byte),                   // show-ahead head
        .full   (rx_full),
        .empty  (rx_empty)
    );

endmodule : uart

// File: hw/uart_rx_deserializer.sv
// uart_rx_deserializer: input synchronizer, start bit check and 8N1 byte sampling
`timescale 1ns/10ps

module uart_rx_deserializer (
    input  logic                       clk,
    input  logic                       rst,
    input  uart_cfg_pkg::baud_div_t    baud_div,
    input  logic                       rx_pin,
    output logic                       byte_valid,
    output uart_frame_pkg::data_byte_t data
);
    import uart_cfg_pkg::*;
    import uart_frame_pkg::*;

    localparam bit_index_t LAST_BIT = bit_index_t'(DATA_BITS - 1);

    logic [1:0] sync_q;                      // two-flop synchronizer
    logic       rx_s;                        // synchronized line
    logic       rx_prev;                     // previous value, for edge detect
    logic       fall;
    rx_state_t  state;
    baud_div_t  bit_timer;
    bit_index_t bit_index;
    logic       bit_end;

    assign rx_s    = sync_q[1];
    assign fall    = rx_prev && !rx_s;
    assign bit_end = (bit_timer == '0);

    // reset to the idle level so reset release does not look like a start bit
    always_ff @(posedge clk) begin
        if (!rst) begin
            sync_q  <= {2{LINE_IDLE}};
            rx_prev <= LINE_IDLE;
        end else begin
            sync_q  <= {sync_q[0], rx_pin};
            rx_prev <= rx_s;
        end
    end

    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_end) data[bit_index] <= rx_s;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state      <= RX_IDLE;
            bit_timer  <= '0;
            bit_index  <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;                // one-cycle strobe
            case (state)
                RX_IDLE: begin
                    if (fall) begin
                        state     <= RX_START;
                        bit_timer <= baud_div >> 1;  // half a bit to the middle
                        bit_index <= '0;
                    end
                end

                RX_START: begin
                    if (!bit_end) begin
                        bit_timer <= bit_timer - 1'b1;
                    end else if (rx_s == LINE_IDLE) begin
                        state <= RX_IDLE;      // glitch, line already back high
                    end else begin
                        state     <= RX_DATA;
                        bit_timer <= baud_div;
                    end
                end

                RX_DATA: begin
                    if (bit_end) begin
                        bit_timer <= baud_div;
                        if (bit_index == LAST_BIT) state <= RX_STOP;
                        else bit_index <= bit_index + 1'b1;
                    end else begin
                        bit_timer <= bit_timer - 1'b1;
                    end
                end

                // wait one bit time, the stop level itself is not checked
                RX_STOP: begin
                    if (bit_end) begin
                        byte_valid <= 1'b1;
                        state      <= RX_IDLE;
                    end else begin
                        bit_timer <= bit_timer - 1'b1;
                    end
                end

                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule : uart_rx_deserializer

// File: hw/uart_tx_serializer.sv
// uart_tx_serializer: shifts one byte out as an 8N1 frame on the transmit pin
`timescale 1ns/10ps

module uart_tx_serializer (
    input  logic                       clk,
    input  logic                       rst,
    input  uart_cfg_pkg::baud_div_t    baud_div,
    input  logic                       load,
    input  uart_frame_pkg::data_byte_t data,
    output logic                       tx_pin,
    output logic                       idle
);
    import uart_cfg_pkg::*;
    import uart_frame_pkg::*;

    localparam bit_index_t LAST_BIT = bit_index_t'(DATA_BITS - 1);

    tx_state_t  state;
    baud_div_t  bit_timer;                   // counts down from baud_div
    bit_index_t bit_index;
    data_byte_t data_latch;
    logic       bit_end;

    assign bit_end = (bit_timer == '0);

    // also high in the last cycle of the stop bit, so frames can run back to back
    assign idle = (state == TX_IDLE) || (state == TX_STOP && bit_end);

    always_ff @(posedge clk) begin
        if (load && idle) data_latch <= data;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= TX_IDLE;
            bit_timer <= '0;
            bit_index <= '0;
            tx_pin    <= LINE_IDLE;
        end else if (load && idle) begin
            state     <= TX_START;
            bit_timer <= baud_div;
            bit_index <= '0;
            tx_pin    <= ~LINE_IDLE;           // start bit on the next cycle
        end else begin
            case (state)
                TX_IDLE: begin
                    tx_pin <= LINE_IDLE;
                end

                TX_START: begin
                    if (bit_end) begin
                        state     <= TX_DATA;
                        bit_timer <= baud_div;
                        tx_pin    <= data_latch[0];  // LSB first
                    end else begin
                        bit_timer <= bit_timer - 1'b1;
                    end
                end

                TX_DATA: begin
                    if (bit_end) begin
                        bit_timer <= baud_div;
                        if (bit_index == LAST_BIT) begin
                            state  <= TX_STOP;
                            tx_pin <= LINE_IDLE;
                        end else begin
                            bit_index <= bit_index + 1'b1;
                            tx_pin    <= data_latch[bit_index + 1'b1];
                        end
                    end else begin
                        bit_timer <= bit_timer - 1'b1;
                    end
                end

                TX_STOP: begin
                    if (bit_end) state <= TX_IDLE;  // no new load, line stays high
                    else bit_timer <= bit_timer - 1'b1;
                end

                default: begin
                    state  <= TX_IDLE;
                    tx_pin <= LINE_IDLE;
                end
            endcase
        end
    end

endmodule : uart_tx_serializer

// File: hw/byte_fifo.sv
// byte_fifo: synchronous show-ahead byte FIFO with full and empty flags
`timescale 1ns/10ps

module byte_fifo #(
    parameter int FIFO_DEPTH = uart_cfg_pkg::DEFAULT_FIFO_DEPTH  // power of two, at least 2
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      push,
    input  logic                      pop,
    input  uart_frame_pkg::data_byte_t wr_data,
    output uart_frame_pkg::data_byte_t rd_data,
    output logic                      full,
    output logic                      empty
);
    import uart_frame_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [PTR_W:0]   cnt_t;         // one bit wider so a full FIFO is countable

    localparam cnt_t DEPTH_CNT = cnt_t'(FIFO_DEPTH);

    data_byte_t mem [FIFO_DEPTH];
    ptr_t       wr_ptr;
    ptr_t       rd_ptr;
    cnt_t       count;
    logic       do_push;
    logic       do_pop;

    // a push into a full FIFO is lost even with a pop in the same cycle
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full    = (count == DEPTH_CNT);
    assign empty   = (count == '0);
    assign rd_data = mem[rd_ptr];            // head byte, show-ahead

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // both or neither
            endcase
        end
    end

endmodule : byte_fifo

// File: hw/uart_frame_pkg.sv
// serial frame package: data byte, bit index, 8N1 frame constants, TX and RX state enums

package uart_frame_pkg;

    // one character on the line
    typedef logic [7:0] data_byte_t;

    // selects one data bit inside a character
    typedef logic [2:0] bit_index_t;

    localparam int DATA_BITS = 8;            // 8N1, no parity

    // idle level of the line, also the stop bit level
    localparam logic LINE_IDLE = 1'b1;

    // transmit FSM
    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,
        TX_START = 2'd1,
        TX_DATA  = 2'd2,
        TX_STOP  = 2'd3
    } tx_state_t;

    // receive FSM
    typedef enum logic [1:0] {
        RX_IDLE  = 2'd0,
        RX_START = 2'd1,                     // half-bit wait, start bit check
        RX_DATA  = 2'd2,
        RX_STOP  = 2'd3                      // stop bit level is not checked
    } rx_state_t;

endpackage : uart_frame_pkg

// File: hw/uart_cfg_pkg.sv
// configuration package: baud divider type and default FIFO depth

package uart_cfg_pkg;

    // clock cycles per bit, minus one
    // one bit lasts baud_div+1 cycles, values below 3 are not supported
    typedef logic [15:0] baud_div_t;

    // default byte count of each FIFO, must be a power of two
    parameter int DEFAULT_FIFO_DEPTH = 64;

endpackage : uart_cfg_pkg
